//--- design/command_regs.sv
`timescale 1ns/1ps
`include "step_drive_defines.svh"

module command_regs
(
    input  logic                             clk,
    input  logic                             rst,
    input  logic [`STEP_ADDR_W-1:0]          s_awaddr,
    input  logic                             s_awvalid,
    output logic                             s_awready,
    input  logic [`STEP_DATA_W-1:0]          s_wdata,
    input  logic                             s_wvalid,
    output logic                             s_wready,
    output step_drive_pkg::axi_resp_e        s_bresp,
    output logic                             s_bvalid,
    input  logic                             s_bready,
    input  logic [`STEP_ADDR_W-1:0]          s_araddr,
    input  logic                             s_arvalid,
    output logic                             s_arready,
    output logic [`STEP_DATA_W-1:0]          s_rdata,
    output step_drive_pkg::axi_resp_e        s_rresp,
    output logic                             s_rvalid,
    input  logic                             s_rready,
    output step_drive_pkg::mode_cfg_t        tr_cfg,
    output step_drive_pkg::mode_cfg_t        tx_cfg,
    output step_drive_pkg::mode_cfg_t        tp_cfg,
    output logic signed [`STEP_DATA_W-1:0]   detuning,
    output logic                             restart,
    output logic                             track_en,
    input  step_drive_pkg::mode_e            mode,
    input  logic signed [`STEP_DATA_W-1:0]   fi_phm,
    input  logic [`STEP_DATA_W-1:0]          track_cnt
);
    // address and data are captured independently, so AW and W may come in any order
    logic                      aw_full;
    logic [`STEP_ADDR_W-1:0]   aw_addr;
    logic                      w_full;
    logic [`STEP_DATA_W-1:0]   w_data;
    logic                      wr_fire;
    step_drive_pkg::axi_resp_e wr_resp;
    logic [`STEP_DATA_W-1:0]   rd_word;
    step_drive_pkg::axi_resp_e rd_resp;

    // the write is performed once both halves are held and no response is pending
    assign wr_fire = aw_full && w_full && !s_bvalid;

    // only the configuration, target and control words accept writes
    always_comb
    begin
        case (aw_addr)
            `REG_TR_CFG, `REG_TR_CFG + 6'd4,
            `REG_TX_CFG, `REG_TX_CFG + 6'd4,
            `REG_TP_CFG, `REG_TP_CFG + 6'd4,
            `REG_DETUNING, `REG_CTRL: wr_resp = step_drive_pkg::OKAY;
            default:                  wr_resp = step_drive_pkg::SLVERR;
        endcase
    end

    // read decode, status, position and track count are taken live from the datapath
    always_comb
    begin
        rd_word = '0;
        rd_resp = step_drive_pkg::OKAY;
        case (s_araddr)
            `REG_TR_CFG:        rd_word = tr_cfg.period;
            `REG_TR_CFG + 6'd4: rd_word[1:0] = {tr_cfg.dir, tr_cfg.drv_en};
            `REG_TX_CFG:        rd_word = tx_cfg.period;
            `REG_TX_CFG + 6'd4: rd_word[1:0] = {tx_cfg.dir, tx_cfg.drv_en};
            `REG_TP_CFG:        rd_word = tp_cfg.period;
            `REG_TP_CFG + 6'd4: rd_word[1:0] = {tp_cfg.dir, tp_cfg.drv_en};
            `REG_DETUNING:      rd_word = detuning;
            // restart always reads back as zero since it clears itself
            `REG_CTRL:          rd_word[1:0] = {track_en, 1'b0};
            `REG_STATUS:        rd_word[1:0] = mode;
            `REG_POSITION:      rd_word = fi_phm;
            `REG_TRACK_CNT:     rd_word = track_cnt;
            default:            rd_resp = step_drive_pkg::SLVERR;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            s_awready <= 1'b0;
            s_wready  <= 1'b0;
            s_bvalid  <= 1'b0;
            s_arready <= 1'b0;
            s_rvalid  <= 1'b0;
            aw_full   <= 1'b0;
            w_full    <= 1'b0;
            tr_cfg    <= '{period: `STEP_RESET_PERIOD, dir: 1'b0, drv_en: 1'b0};
            tx_cfg    <= '{period: `STEP_RESET_PERIOD, dir: 1'b0, drv_en: 1'b0};
            tp_cfg    <= '{period: `STEP_RESET_PERIOD, dir: 1'b0, drv_en: 1'b0};
            detuning  <= '0;
            restart   <= 1'b0;
            track_en  <= 1'b0;
        end
        else
        begin
            // ready rises one cycle after valid and drops right after the handshake
            // a held address or a waiting response keeps the channel closed
            s_awready <= s_awvalid && !s_awready && !aw_full && !s_bvalid;
            s_wready  <= s_wvalid && !s_wready && !w_full && !s_bvalid;
            s_arready <= s_arvalid && !s_arready && !s_rvalid;
            if (s_awvalid && s_awready)
                aw_full <= 1'b1;
            if (s_wvalid && s_wready)
                w_full <= 1'b1;
            restart <= 1'b0;
            if (wr_fire)
            begin
                aw_full  <= 1'b0;
                w_full   <= 1'b0;
                s_bvalid <= 1'b1;
                case (aw_addr)
                    `REG_TR_CFG:        tr_cfg.period <= w_data;
                    `REG_TR_CFG + 6'd4: {tr_cfg.dir, tr_cfg.drv_en} <= w_data[1:0];
                    `REG_TX_CFG:        tx_cfg.period <= w_data;
                    `REG_TX_CFG + 6'd4: {tx_cfg.dir, tx_cfg.drv_en} <= w_data[1:0];
                    `REG_TP_CFG:        tp_cfg.period <= w_data;
                    `REG_TP_CFG + 6'd4: {tp_cfg.dir, tp_cfg.drv_en} <= w_data[1:0];
                    `REG_DETUNING:      detuning <= w_data;
                    `REG_CTRL:          {track_en, restart} <= w_data[1:0];
                    default:            ;
                endcase
            end
            else if (s_bvalid && s_bready)
                s_bvalid <= 1'b0;
            // read data shows up one cycle after the AR handshake
            if (s_arvalid && s_arready)
                s_rvalid <= 1'b1;
            else if (s_rvalid && s_rready)
                s_rvalid <= 1'b0;
        end
    end

    // captured address, data and response words
    always_ff @(posedge clk)
    begin
        if (s_awvalid && s_awready)
            aw_addr <= s_awaddr;
        if (s_wvalid && s_wready)
            w_data <= s_wdata;
        if (wr_fire)
            s_bresp <= wr_resp;
        if (s_arvalid && s_arready)
        begin
            s_rdata <= rd_word;
            s_rresp <= rd_resp;
        end
    end

endmodule

//--- design/drive_mux.sv
`timescale 1ns/1ps

module drive_mux
(
    input  step_drive_pkg::mode_e      mode,
    input  step_drive_pkg::mode_cfg_t  tr_cfg,
    input  step_drive_pkg::mode_cfg_t  tx_cfg,
    input  step_drive_pkg::mode_cfg_t  tp_cfg,
    input  logic                       track_en,
    output step_drive_pkg::drive_cmd_t cmd,
    output logic                       drv_dir,
    output logic                       drv_en
);
    step_drive_pkg::mode_cfg_t sel_cfg;

    // pick the configuration of the mode the controller is in right now
    // an undefined mode code falls back to the tracking settings
    always_comb
    begin
        case (mode)
            step_drive_pkg::TX: sel_cfg = tx_cfg;
            step_drive_pkg::TP: sel_cfg = tp_cfg;
            default:            sel_cfg = tr_cfg;
        endcase
    end

    // steps only count toward the tracking total while tracking with counting on
    always_comb
    begin
        cmd.period     = sel_cfg.period;
        cmd.dir        = sel_cfg.dir;
        cmd.enable     = sel_cfg.drv_en;
        cmd.counter_en = (mode == step_drive_pkg::TR) && track_en;
    end

    // motor pins follow the selected mode with no extra latency
    // the enable pin switches the power stage, direction is held even while disabled
    assign drv_dir = sel_cfg.dir;
    assign drv_en  = sel_cfg.drv_en;

endmodule

//--- design/mode_fsm.sv
`timescale 1ns/1ps
`include "step_drive_defines.svh"

module mode_fsm
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           restart,
    input  logic                           syncpulse,
    input  logic signed [`STEP_DATA_W-1:0] fi_phm,
    input  logic signed [`STEP_DATA_W-1:0] detuning,
    output step_drive_pkg::mode_e          mode
);
    step_drive_pkg::mode_e mode_next;

    // next mode decode, every case not listed holds the current mode
    always_comb
    begin
        mode_next = mode;
        if (restart)
        begin
            // software restart wins over every other condition
            mode_next = step_drive_pkg::TR;
        end
        else
        begin
            case (mode)
                step_drive_pkg::TR:
                begin
                    // tracking hands over to transfer on the external sync
                    if (syncpulse)
                        mode_next = step_drive_pkg::TX;
                end
                step_drive_pkg::TX:
                begin
                    // transfer ends once the phase lands exactly on the target
                    if (fi_phm == detuning)
                        mode_next = step_drive_pkg::TP;
                end
                step_drive_pkg::TP:
                begin
                    // overshooting the target drops back into transfer
                    // both operands are signed so a negative phase compares correctly
                    if (fi_phm > detuning)
                        mode_next = step_drive_pkg::TX;
                end
                default:
                    mode_next = step_drive_pkg::TR;
            endcase
        end
    end

    // the new mode is registered one cycle after its condition
    always_ff @(posedge clk)
    begin
        if (rst)
            mode <= step_drive_pkg::TR;
        else
            mode <= mode_next;
    end

endmodule

//--- design/step_drive_defines.svh
`ifndef STEP_DRIVE_DEFINES_SVH
`define STEP_DRIVE_DEFINES_SVH

// width of every register word, step period and phase position
`define STEP_DATA_W 32

// byte address width of the AXI4-Lite register window
`define STEP_ADDR_W 6

// each mode block is a period word at the base and a flags word at base + 4
// flags bit0 enables the drive, bit1 selects the direction
`define REG_TR_CFG 6'h00
`define REG_TX_CFG 6'h08
`define REG_TP_CFG 6'h10

// control and target registers, ctrl bit0 is restart and bit1 is track enable
`define REG_DETUNING 6'h18
`define REG_CTRL 6'h1C

// read-only views of the live controller state
`define REG_STATUS 6'h20
`define REG_POSITION 6'h24
`define REG_TRACK_CNT 6'h28

// step period loaded into every mode configuration out of reset
`define STEP_RESET_PERIOD 32'd100

`endif

//--- design/step_drive_pkg.sv
`include "step_drive_defines.svh"

package step_drive_pkg;

    // operating modes of the drive, tracking, transfer and positioning
    typedef enum logic [1:0]
    {
        TR = 2'd0,
        TX = 2'd1,
        TP = 2'd2
    } mode_e;

    // AXI response codes used by the register slave
    // only OKAY and SLVERR are ever returned
    typedef enum logic [1:0]
    {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_e;

    // per-mode configuration as programmed by the processor
    // the period counts clock cycles between two step pulses
    typedef struct packed
    {
        logic [`STEP_DATA_W-1:0] period;
        logic                    dir;
        logic                    drv_en;
    } mode_cfg_t;

    // command handed from the drive multiplexer to the step timer
    // counter_en marks steps that count toward the tracking total
    typedef struct packed
    {
        logic [`STEP_DATA_W-1:0] period;
        logic                    dir;
        logic                    enable;
        logic                    counter_en;
    } drive_cmd_t;

endpackage

//--- design/step_drive_top.sv
`timescale 1ns/1ps
`include "step_drive_defines.svh"

module step_drive_top
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`STEP_ADDR_W-1:0]   s_awaddr,
    input  logic                      s_awvalid,
    output logic                      s_awready,
    input  logic [`STEP_DATA_W-1:0]   s_wdata,
    input  logic                      s_wvalid,
    output logic                      s_wready,
    output step_drive_pkg::axi_resp_e s_bresp,
    output logic                      s_bvalid,
    input  logic                      s_bready,
    input  logic [`STEP_ADDR_W-1:0]   s_araddr,
    input  logic                      s_arvalid,
    output logic                      s_arready,
    output logic [`STEP_DATA_W-1:0]   s_rdata,
    output step_drive_pkg::axi_resp_e s_rresp,
    output logic                      s_rvalid,
    input  logic                      s_rready,
    input  logic                      syncpulse,
    output logic                      step,
    output logic                      drv_dir,
    output logic                      drv_en
);
    // configuration buses from the register file
    step_drive_pkg::mode_cfg_t        tr_cfg;
    step_drive_pkg::mode_cfg_t        tx_cfg;
    step_drive_pkg::mode_cfg_t        tp_cfg;
    logic signed [`STEP_DATA_W-1:0]   detuning;
    logic                             restart;
    logic                             track_en;
    // controller state fed back for mode decisions and readback
    step_drive_pkg::mode_e            mode;
    step_drive_pkg::drive_cmd_t       cmd;
    logic signed [`STEP_DATA_W-1:0]   fi_phm;
    logic [`STEP_DATA_W-1:0]          track_cnt;

    command_regs u_command_regs (.*);

    mode_fsm u_mode_fsm
    (
        .clk(clk), .rst(rst), .restart(restart), .syncpulse(syncpulse),
        .fi_phm(fi_phm), .detuning(detuning), .mode(mode)
    );

    drive_mux u_drive_mux
    (
        .mode(mode), .tr_cfg(tr_cfg), .tx_cfg(tx_cfg), .tp_cfg(tp_cfg),
        .track_en(track_en), .cmd(cmd), .drv_dir(drv_dir), .drv_en(drv_en)
    );

    step_timer u_step_timer
    (
        .clk(clk), .rst(rst), .cmd(cmd), .mode(mode),
        .step(step), .fi_phm(fi_phm), .track_cnt(track_cnt)
    );

endmodule

//--- design/step_timer.sv
`timescale 1ns/1ps
`include "step_drive_defines.svh"

module step_timer
(
    input  logic                           clk,
    input  logic                           rst,
    input  step_drive_pkg::drive_cmd_t     cmd,
    input  step_drive_pkg::mode_e          mode,
    output logic                           step,
    output logic signed [`STEP_DATA_W-1:0] fi_phm,
    output logic [`STEP_DATA_W-1:0]        track_cnt
);
    logic [`STEP_DATA_W-1:0] cnt;
    logic [`STEP_DATA_W-1:0] period_eff;
    step_drive_pkg::mode_e   mode_q;
    logic                    reload;
    logic                    fire;

    // a period of 0 or 1 would leave no low cycle between pulses, so clamp it to 2
    assign period_eff = (cmd.period < `STEP_DATA_W'd2) ? `STEP_DATA_W'd2 : cmd.period;

    // restart the interval whenever the mode switches or the drive is off
    assign reload = (mode != mode_q) || !cmd.enable;
    assign fire   = !reload && (cnt == '0);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            mode_q    <= step_drive_pkg::TR;
            cnt       <= '0;
            step      <= 1'b0;
            fi_phm    <= '0;
            track_cnt <= '0;
        end
        else
        begin
            mode_q <= mode;
            step   <= fire;
            // counting down from period - 1 spaces pulses exactly period cycles apart
            if (reload || fire)
                cnt <= period_eff - `STEP_DATA_W'd1;
            else
                cnt <= cnt - `STEP_DATA_W'd1;
            // position moves together with the pulse, up when dir is set
            if (fire)
            begin
                if (cmd.dir)
                    fi_phm <= fi_phm + 1;
                else
                    fi_phm <= fi_phm - 1;
                if (cmd.counter_en)
                    track_cnt <= track_cnt + `STEP_DATA_W'd1;
            end
        end
    end

endmodule

//--- step_drive.f
+incdir+design
design/step_drive_pkg.sv
design/command_regs.sv
design/mode_fsm.sv
design/drive_mux.sv
design/step_timer.sv
design/step_drive_top.sv
tests/step_drive_sva.sv
tests/step_drive_tb.sv

//--- tests/step_drive_sva.sv
`timescale 1ns/1ps
`include "step_drive_defines.svh"

module step_drive_sva
(
    input logic                    clk,
    input logic                    rst,
    input logic                    b_valid,
    input logic                    b_ready,
    input logic                    r_valid,
    input logic                    r_ready,
    input logic                    step,
    input logic [`STEP_DATA_W-1:0] fi_phm
);
    // a response that is not yet taken must stay offered to the master
    a_b_hold: assert property (@(posedge clk) disable iff (rst) b_valid && !b_ready |=> b_valid)
        else $error("bvalid dropped before bready");
    a_r_hold: assert property (@(posedge clk) disable iff (rst) r_valid && !r_ready |=> r_valid)
        else $error("rvalid dropped before rready");

    // the clamped period keeps at least one low cycle between pulses
    a_step_pulse: assert property (@(posedge clk) disable iff (rst) step |=> !step)
        else $error("step high for two cycles in a row");

    // the position register and the pulse are updated on the same edge
    a_phm_on_step: assert property (@(posedge clk) disable iff (rst)
        fi_phm != $past(fi_phm) |-> step)
        else $error("fi_phm moved without a step pulse");

endmodule

// the handshake checks see only the register slave, the step ports are tied off there
bind command_regs step_drive_sva u_regs_sva
(
    .clk(clk), .rst(rst), .b_valid(s_bvalid), .b_ready(s_bready),
    .r_valid(s_rvalid), .r_ready(s_rready), .step(1'b0), .fi_phm({`STEP_DATA_W{1'b0}})
);

// the timer instance carries no AXI traffic
bind step_timer step_drive_sva u_timer_sva
(
    .clk(clk), .rst(rst), .b_valid(1'b0), .b_ready(1'b0),
    .r_valid(1'b0), .r_ready(1'b0), .step(step), .fi_phm(fi_phm)
);

//--- tests/step_drive_tb.sv
`timescale 1ns/1ps
`include "step_drive_defines.svh"

module step_drive_tb;

    // the longest test needs about 40 pulses of up to 15 cycles and about 60 bus accesses
    localparam int CYCLE_LIMIT = 20000;

    logic clk;
    logic rst;
    logic [`STEP_ADDR_W-1:0]   s_awaddr;
    logic                      s_awvalid;
    logic                      s_awready;
    logic [`STEP_DATA_W-1:0]   s_wdata;
    logic                      s_wvalid;
    logic                      s_wready;
    step_drive_pkg::axi_resp_e s_bresp;
    logic                      s_bvalid;
    logic                      s_bready;
    logic [`STEP_ADDR_W-1:0]   s_araddr;
    logic                      s_arvalid;
    logic                      s_arready;
    logic [`STEP_DATA_W-1:0]   s_rdata;
    step_drive_pkg::axi_resp_e s_rresp;
    logic                      s_rvalid;
    logic                      s_rready;
    logic                      syncpulse;
    logic                      step;
    logic                      drv_dir;
    logic                      drv_en;

    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_failed = 0;
    int err_mark = 0;
    int last_step = 0;

    // model of what has been programmed and where the drive should be
    step_drive_pkg::mode_cfg_t      cfg_model [0:2];
    step_drive_pkg::mode_e          exp_mode;
    logic signed [`STEP_DATA_W-1:0] exp_pos;
    logic signed [`STEP_DATA_W-1:0] det;
    logic [`STEP_DATA_W-1:0]        exp_track;
    logic                           track_on;
    logic                           interval_on;
    logic                           have_last;

    step_drive_top UUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // restart wins first, then sync leaves TR, equality ends TX and overshoot ends TP
    function automatic step_drive_pkg::mode_e next_mode(input step_drive_pkg::mode_e cur,
        input logic rs, input logic sy, input logic signed [31:0] pos,
        input logic signed [31:0] target);
        next_mode = cur;
        if (rs)
            next_mode = step_drive_pkg::TR;
        else if (cur == step_drive_pkg::TR && sy)
            next_mode = step_drive_pkg::TX;
        else if (cur == step_drive_pkg::TX && pos == target)
            next_mode = step_drive_pkg::TP;
        else if (cur == step_drive_pkg::TP && pos > target)
            next_mode = step_drive_pkg::TX;
    endfunction

    // each step moves the phase one count up when dir is set and one count down otherwise
    function automatic logic signed [31:0] pos_after(input logic signed [31:0] pos,
        input logic dir, input int n);
        pos_after = dir ? pos + n : pos - n;
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic check_mode(input string name, input step_drive_pkg::mode_e got,
        input step_drive_pkg::mode_e exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic check_resp(input string name, input step_drive_pkg::axi_resp_e got,
        input step_drive_pkg::axi_resp_e exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Fail at %0t: %s got %s expected %s", $time, name, got.name(), exp.name());
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_mark)
            $display("test %0d %s: ok", tests_run, name);
        else
        begin
            tests_failed++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // AW and W are offered together and each drops on the edge after its handshake
    // hold keeps bready low for that many cycles once the response is up
    task automatic axi_write(input logic [5:0] addr, input logic [31:0] data, input int hold,
        output step_drive_pkg::axi_resp_e resp);
        logic aw_done;
        logic w_done;
        logic aw_hs;
        logic w_hs;
        @(negedge clk);
        s_awaddr = addr;
        s_awvalid = 1'b1;
        s_wdata = data;
        s_wvalid = 1'b1;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done))
        begin
            aw_hs = s_awvalid && s_awready;
            w_hs = s_wvalid && s_wready;
            @(negedge clk);
            if (aw_hs)
            begin
                s_awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs)
            begin
                s_wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
        while (!s_bvalid)
            @(negedge clk);
        repeat (hold)
        begin
            @(negedge clk);
            check_word("s_bvalid", s_bvalid, 1'b1);
        end
        s_bready = 1'b1;
        resp = s_bresp;
        @(negedge clk);
        s_bready = 1'b0;
    endtask

    task automatic axi_read(input logic [5:0] addr, output logic [31:0] data,
        output step_drive_pkg::axi_resp_e resp);
        logic ar_hs;
        @(negedge clk);
        s_araddr = addr;
        s_arvalid = 1'b1;
        ar_hs = 1'b0;
        while (!ar_hs)
        begin
            ar_hs = s_arvalid && s_arready;
            @(negedge clk);
        end
        s_arvalid = 1'b0;
        while (!s_rvalid)
            @(negedge clk);
        s_rready = 1'b1;
        data = s_rdata;
        resp = s_rresp;
        @(negedge clk);
        s_rready = 1'b0;
    endtask

    task automatic reg_write(input logic [5:0] addr, input logic [31:0] data);
        step_drive_pkg::axi_resp_e resp;
        axi_write(addr, data, 0, resp);
        check_resp("s_bresp", resp, step_drive_pkg::OKAY);
    endtask

    task automatic reg_read(input logic [5:0] addr, output logic [31:0] data);
        step_drive_pkg::axi_resp_e resp;
        axi_read(addr, data, resp);
        check_resp("s_rresp", resp, step_drive_pkg::OKAY);
    endtask

    task automatic pulse_sync();
        @(negedge clk);
        syncpulse = 1'b1;
        @(negedge clk);
        syncpulse = 1'b0;
    endtask

    // free-running cycle count doubles as the hang guard
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // every step pulse advances the model and is checked against it
    always @(negedge clk)
    begin
        if (!rst && step)
        begin
            if (interval_on && have_last)
                check_word("step interval", cycles - last_step,
                    (cfg_model[exp_mode].period < 2) ? 2 : cfg_model[exp_mode].period);
            last_step = cycles;
            have_last = 1'b1;
            if (exp_mode == step_drive_pkg::TR && track_on)
                exp_track = exp_track + 1;
            exp_pos = pos_after(exp_pos, cfg_model[exp_mode].dir, 1);
            check_word("fi_phm", UUT.fi_phm, exp_pos);
            exp_mode = next_mode(exp_mode, 1'b0, 1'b0, exp_pos, det);
        end
    end

    initial
    begin
        logic [31:0] rd;
        logic [31:0] data;
        int p;
        int cnt;
        step_drive_pkg::axi_resp_e resp;
        void'($urandom(30112));
        rst = 1'b1;
        s_awaddr = '0;
        s_awvalid = 1'b0;
        s_wdata = '0;
        s_wvalid = 1'b0;
        s_bready = 1'b0;
        s_araddr = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        syncpulse = 1'b0;
        for (int i = 0; i < 3; i++)
            cfg_model[i] = '{period: `STEP_RESET_PERIOD, dir: 1'b0, drv_en: 1'b0};
        exp_mode = step_drive_pkg::TR;
        exp_pos = '0;
        det = '0;
        exp_track = '0;
        track_on = 1'b0;
        interval_on = 1'b0;
        have_last = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // reset values, random readback and unmapped addresses
        reg_read(`REG_TR_CFG, rd);
        check_word("tr period", rd, `STEP_RESET_PERIOD);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        reg_read(`REG_POSITION, rd);
        check_word("position", rd, exp_pos);
        reg_read(`REG_TRACK_CNT, rd);
        check_word("track count", rd, exp_track);
        data = $urandom;
        reg_write(`REG_TX_CFG, data);
        reg_read(`REG_TX_CFG, rd);
        check_word("tx period", rd, data);
        data = $urandom;
        reg_write(`REG_TP_CFG, data);
        reg_read(`REG_TP_CFG, rd);
        check_word("tp period", rd, data);
        det = $urandom;
        reg_write(`REG_DETUNING, det);
        reg_read(`REG_DETUNING, rd);
        check_word("detuning", rd, det);
        data = $urandom & 32'h3;
        reg_write(`REG_TX_CFG + 6'd4, data);
        reg_read(`REG_TX_CFG + 6'd4, rd);
        check_word("tx flags", rd, data);
        axi_write(6'h2C, $urandom, 0, resp);
        check_resp("unmapped bresp", resp, step_drive_pkg::SLVERR);
        axi_write(`REG_STATUS, $urandom, 0, resp);
        check_resp("status bresp", resp, step_drive_pkg::SLVERR);
        axi_read(6'h30, rd, resp);
        check_resp("unmapped rresp", resp, step_drive_pkg::SLVERR);
        finish_test("register access");

        // in tracking with counting on the pulses must be exactly one period apart
        p = 4 + $urandom % 12;
        track_on = 1'b1;
        reg_write(`REG_CTRL, 32'h2);
        cfg_model[step_drive_pkg::TR] = '{period: p, dir: 1'b1, drv_en: 1'b1};
        reg_write(`REG_TR_CFG, p);
        interval_on = 1'b1;
        have_last = 1'b0;
        reg_write(`REG_TR_CFG + 6'd4, 32'h3);
        while (!step)
            @(negedge clk);
        cnt = 0;
        repeat (6 * p)
        begin
            @(negedge clk);
            if (step)
                cnt++;
        end
        check_word("step count", cnt, 6);
        check_word("drv_dir", drv_dir, cfg_model[step_drive_pkg::TR].dir);
        check_word("drv_en", drv_en, cfg_model[step_drive_pkg::TR].drv_en);
        cfg_model[step_drive_pkg::TR].drv_en = 1'b0;
        reg_write(`REG_TR_CFG + 6'd4, 32'h2);
        interval_on = 1'b0;
        reg_read(`REG_POSITION, rd);
        check_word("position", rd, exp_pos);
        finish_test("tracking steps");

        // sync hands over to transfer and the pins follow the transfer settings
        cfg_model[step_drive_pkg::TX] = '{period: 4 + $urandom % 8, dir: 1'b0, drv_en: 1'b0};
        cfg_model[step_drive_pkg::TP] = '{period: 4 + $urandom % 8, dir: 1'b1, drv_en: 1'b0};
        reg_write(`REG_TX_CFG + 6'd4, 32'h0);
        reg_write(`REG_TP_CFG + 6'd4, 32'h2);
        reg_write(`REG_TX_CFG, cfg_model[step_drive_pkg::TX].period);
        reg_write(`REG_TP_CFG, cfg_model[step_drive_pkg::TP].period);
        det = exp_pos + 3 + $urandom % 4;
        reg_write(`REG_DETUNING, det);
        pulse_sync();
        exp_mode = next_mode(exp_mode, 1'b0, 1'b1, exp_pos, det);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        check_word("drv_dir", drv_dir, cfg_model[step_drive_pkg::TX].dir);
        check_word("drv_en", drv_en, cfg_model[step_drive_pkg::TX].drv_en);
        cfg_model[step_drive_pkg::TX].dir = 1'b1;
        cfg_model[step_drive_pkg::TX].drv_en = 1'b1;
        reg_write(`REG_TX_CFG + 6'd4, 32'h3);
        check_word("drv_dir", drv_dir, cfg_model[step_drive_pkg::TX].dir);
        check_word("drv_en", drv_en, cfg_model[step_drive_pkg::TX].drv_en);
        finish_test("sync to transfer");

        // transfer stops on the target while positioning overshoots and falls back
        do
            reg_read(`REG_POSITION, rd);
        while (rd !== det);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        cfg_model[step_drive_pkg::TP].drv_en = 1'b1;
        reg_write(`REG_TP_CFG + 6'd4, 32'h3);
        do
            reg_read(`REG_STATUS, rd);
        while (rd[1:0] == step_drive_pkg::TP);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        cfg_model[step_drive_pkg::TX].drv_en = 1'b0;
        reg_write(`REG_TX_CFG + 6'd4, 32'h2);
        cfg_model[step_drive_pkg::TP].drv_en = 1'b0;
        reg_write(`REG_TP_CFG + 6'd4, 32'h2);
        reg_read(`REG_POSITION, rd);
        check_word("position", rd, exp_pos);
        finish_test("transfer and positioning");

        // steps in TX and TP must not have reached the tracking total
        reg_read(`REG_TRACK_CNT, rd);
        check_word("track count", rd, exp_track);
        finish_test("tracking count");

        // restart from TX, then from TP, then from TR itself
        reg_write(`REG_CTRL, 32'h3);
        exp_mode = next_mode(exp_mode, 1'b1, 1'b0, exp_pos, det);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        det = exp_pos;
        reg_write(`REG_DETUNING, det);
        pulse_sync();
        exp_mode = next_mode(exp_mode, 1'b0, 1'b1, exp_pos, det);
        exp_mode = next_mode(exp_mode, 1'b0, 1'b0, exp_pos, det);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        reg_write(`REG_CTRL, 32'h3);
        exp_mode = next_mode(exp_mode, 1'b1, 1'b0, exp_pos, det);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        reg_write(`REG_CTRL, 32'h3);
        reg_read(`REG_STATUS, rd);
        check_mode("status", step_drive_pkg::mode_e'(rd[1:0]), exp_mode);
        // a stalled response must still carry the write through
        data = $urandom;
        axi_write(`REG_TR_CFG, data, 8, resp);
        check_resp("s_bresp", resp, step_drive_pkg::OKAY);
        reg_read(`REG_TR_CFG, rd);
        check_word("tr period", rd, data);
        finish_test("restart and back-pressure");

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
            tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule
